// File: rtl/gomoku_defines.svh
// Gomoku board constants
`ifndef GOMOKU_DEFINES_SVH
`define GOMOKU_DEFINES_SVH

// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// board geometry
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`define GOMOKU_BOARD_N 15    // cells along one side
`define GOMOKU_CELLS 225     // board_n squared, row-major

// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// search limits
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`define GOMOKU_MAX_DEPTH 3   // nodes in the search chain
`define GOMOKU_WIN_LEN 5     // stones in a row that win

`endif

// File: rtl/board_pkg.sv
// Gomoku board types
`include "gomoku_defines.svh"

package board_pkg;

// state of one intersection
typedef enum logic [1:0] {
    cell_empty    = 2'd0,
    cell_attacker = 2'd1,
    cell_defender = 2'd2
} cell_e;

// column and row of a cell, both 0 to board_n-1
typedef struct packed {
    logic [3:0] x;
    logic [3:0] y;
} pos_t;

// whole board, cell (x, y) sits at index y*board_n + x
typedef cell_e [`GOMOKU_CELLS-1:0] board_t;

// flat index of a cell
function automatic int cell_idx(input int x, input int y);
    return y * `GOMOKU_BOARD_N + x;
endfunction

endpackage

// File: rtl/search_pkg.sv
// Search node traffic types
package search_pkg;

import board_pkg::*;

// request handed from one node to the next
typedef struct packed {
    board_t     board;
    logic [1:0] depth;   // remaining levels, 0 means nothing to search
} node_req_t;

// answer of a node, pos is 0,0 when nothing was found
typedef struct packed {
    logic found;
    pos_t pos;
} node_rsp_t;

endpackage

// File: rtl/orth_runs.sv
// Row and column run counter
`include "gomoku_defines.svh"

module orth_runs import board_pkg::*; (
    input  board_t     i_board,
    input  pos_t       i_pos,
    input  cell_e      i_colour,
    output logic [3:0] o_run_h,
    output logic [3:0] o_run_v
);

localparam int reach = `GOMOKU_WIN_LEN - 1;  // cells looked at on each side

always_comb begin
    int   x;
    int   y;
    logic go_w;
    logic go_e;
    logic go_n;
    logic go_s;
    x    = int'(i_pos.x);
    y    = int'(i_pos.y);
    go_w = 1'b1;
    go_e = 1'b1;
    go_n = 1'b1;
    go_s = 1'b1;
    o_run_h = 4'd1;  // the probe itself counts as one stone
    o_run_v = 4'd1;
    for (int k = 1; k <= reach; k++) begin
        // a walk stops for good at the edge or at the first other colour
        go_w = go_w && (x - k >= 0) && (i_board[cell_idx(x - k, y)] == i_colour);
        go_e = go_e && (x + k < `GOMOKU_BOARD_N) &&
               (i_board[cell_idx(x + k, y)] == i_colour);
        go_n = go_n && (y - k >= 0) && (i_board[cell_idx(x, y - k)] == i_colour);
        go_s = go_s && (y + k < `GOMOKU_BOARD_N) &&
               (i_board[cell_idx(x, y + k)] == i_colour);
        o_run_h = o_run_h + 4'(go_w) + 4'(go_e);
        o_run_v = o_run_v + 4'(go_n) + 4'(go_s);
    end
end

endmodule

// File: rtl/diag_runs.sv
// Diagonal run counter
`include "gomoku_defines.svh"

module diag_runs import board_pkg::*; (
    input  board_t     i_board,
    input  pos_t       i_pos,
    input  cell_e      i_colour,
    output logic [3:0] o_run_d,
    output logic [3:0] o_run_a
);

localparam int reach = `GOMOKU_WIN_LEN - 1;

// stones of colour c met when stepping away from (x, y) by (dx, dy)
function automatic logic [3:0] ray(input board_t b, input int x, input int y,
                                   input int dx, input int dy, input cell_e c);
    int         cx;
    int         cy;
    logic       go;
    logic [3:0] n;
    cx = x;
    cy = y;
    go = 1'b1;
    n  = 4'd0;
    for (int k = 0; k < reach; k++) begin
        cx = cx + dx;
        cy = cy + dy;
        // both coordinates can leave the board on a diagonal
        go = go && (cx >= 0) && (cx < `GOMOKU_BOARD_N) &&
             (cy >= 0) && (cy < `GOMOKU_BOARD_N) &&
             (b[cell_idx(cx, cy)] == c);
        n  = n + 4'(go);
    end
    return n;
endfunction

int px;
int py;

assign px = int'(i_pos.x);
assign py = int'(i_pos.y);

// falling diagonal runs towards higher rows as x grows
assign o_run_d = 4'd1 + ray(i_board, px, py, 1, 1, i_colour) +
                 ray(i_board, px, py, -1, -1, i_colour);

// rising diagonal runs towards lower rows as x grows
assign o_run_a = 4'd1 + ray(i_board, px, py, 1, -1, i_colour) +
                 ray(i_board, px, py, -1, 1, i_colour);

endmodule

// File: rtl/five_judge.sv
// Five in a row judge
`include "gomoku_defines.svh"

module five_judge import board_pkg::*; (
    input  board_t i_board,
    input  pos_t   i_pos,
    input  cell_e  i_colour,
    output logic   o_five
);

logic [3:0] run_h;
logic [3:0] run_v;
logic [3:0] run_d;
logic [3:0] run_a;

orth_runs u_orth_runs (
    .i_board  (i_board),
    .i_pos    (i_pos),
    .i_colour (i_colour),
    .o_run_h  (run_h),
    .o_run_v  (run_v)
);

diag_runs u_diag_runs (
    .i_board  (i_board),
    .i_pos    (i_pos),
    .i_colour (i_colour),
    .o_run_d  (run_d),
    .o_run_a  (run_a)
);

// overlines count as a win as well
assign o_five = (run_h >= 4'(`GOMOKU_WIN_LEN)) || (run_v >= 4'(`GOMOKU_WIN_LEN)) ||
                (run_d >= 4'(`GOMOKU_WIN_LEN)) || (run_a >= 4'(`GOMOKU_WIN_LEN));

endmodule

// File: rtl/kill_node.sv
// Forced win search node
`include "gomoku_defines.svh"

module kill_node import board_pkg::*, search_pkg::*; (
    input  logic      i_clk,
    input  logic      i_rst,
    input  logic      i_start,
    input  node_req_t i_req,
    input  logic      i_child_done,
    input  node_rsp_t i_child_rsp,
    output logic      o_child_start,
    output node_req_t o_child_req,
    output logic      o_done,
    output node_rsp_t o_rsp
);

typedef enum logic [2:0] {st_idle, st_scan, st_threat, st_wait, st_report} state_e;

state_e     state;
board_t     board_q;     // request board held for the whole search
logic [1:0] depth_q;
pos_t       cand;        // candidate cell for the attacker stone
pos_t       probe;       // forced cell cursor that rests on the forced cell in wait
node_rsp_t  rsp_q;
board_t     work_board;
pos_t       judge_pos;
logic       five;
logic       cand_free;
logic       probe_free;
logic       cand_last;
logic       probe_last;

function automatic pos_t next_pos(input pos_t p);
    pos_t n;
    n = p;
    if (p.x == 4'(`GOMOKU_BOARD_N - 1)) begin
        n.x = 4'd0;
        n.y = p.y + 4'd1;
    end else begin
        n.x = p.x + 4'd1;
    end
    return n;
endfunction

// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// working board and five test
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
always_comb begin
    work_board = board_q;
    work_board[cell_idx(int'(cand.x), int'(cand.y))] = cell_attacker;  // candidate stone placed
end

assign judge_pos  = (state == st_threat) ? probe : cand;
assign cand_free  = board_q[cell_idx(int'(cand.x), int'(cand.y))] == cell_empty;
assign probe_free = work_board[cell_idx(int'(probe.x), int'(probe.y))] == cell_empty;
assign cand_last  = (cand.x == 4'(`GOMOKU_BOARD_N - 1)) && (cand.y == 4'(`GOMOKU_BOARD_N - 1));
assign probe_last = (probe.x == 4'(`GOMOKU_BOARD_N - 1)) && (probe.y == 4'(`GOMOKU_BOARD_N - 1));

five_judge u_five_judge (
    .i_board  (work_board),
    .i_pos    (judge_pos),
    .i_colour (cell_attacker),
    .o_five   (five)
);

// the defender blocks the forced cell and the child searches one level less
always_comb begin
    o_child_req.board = work_board;
    o_child_req.board[cell_idx(int'(probe.x), int'(probe.y))] = cell_defender;
    o_child_req.depth = depth_q - 2'd1;
end

// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// search FSM
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
always_ff @(posedge i_clk) begin
    if (state == st_idle && i_start) begin
        board_q <= i_req.board;
        depth_q <= i_req.depth;
    end
end

always_ff @(posedge i_clk) begin
    if (i_rst) begin
        state         <= st_idle;
        o_child_start <= 1'b0;
        rsp_q         <= '0;
        cand          <= '0;
        probe         <= '0;
    end else begin
        o_child_start <= 1'b0;
        case (state)
            st_idle: begin
                if (i_start) begin
                    rsp_q <= '0;
                    cand  <= '0;
                    state <= (i_req.depth == 2'd0) ? st_report : st_scan;
                end
            end
            st_scan: begin
                if (cand_free && five) begin
                    rsp_q.found <= 1'b1;
                    rsp_q.pos   <= cand;
                    state       <= st_report;
                end else if (cand_free && depth_q >= 2'd2) begin
                    probe <= '0;
                    state <= st_threat;
                end else begin
                    cand  <= next_pos(cand);
                    state <= cand_last ? st_report : st_scan;
                end
            end
            st_threat: begin
                if (probe_free && five) begin
                    o_child_start <= 1'b1;
                    state         <= st_wait;
                end else if (probe_last) begin
                    cand  <= next_pos(cand);  // no four means nothing is forced
                    state <= cand_last ? st_report : st_scan;
                end else begin
                    probe <= next_pos(probe);
                end
            end
            st_wait: begin
                if (i_child_done && i_child_rsp.found) begin
                    rsp_q.found <= 1'b1;
                    rsp_q.pos   <= cand;
                    state       <= st_report;
                end else if (i_child_done) begin
                    cand  <= next_pos(cand);
                    state <= cand_last ? st_report : st_scan;
                end
            end
            default: state <= st_idle;  // report lasts one cycle
        endcase
    end
end

assign o_done = (state == st_report);
assign o_rsp  = rsp_q;

// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// checks
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
a_child_depth: assert property (@(posedge i_clk) disable iff (i_rst)
    o_child_start |-> depth_q >= 2'd2);

a_done_pulse: assert property (@(posedge i_clk) disable iff (i_rst)
    o_done |=> !o_done);

// the winning cell must have been empty in the request that started this search
a_win_empty: assert property (@(posedge i_clk) disable iff (i_rst)
    o_done && o_rsp.found |->
        board_q[cell_idx(int'(o_rsp.pos.x), int'(o_rsp.pos.y))] == cell_empty);

endmodule

// File: rtl/kill_search.sv
// Forced win search top
`include "gomoku_defines.svh"

module kill_search import search_pkg::*; (
    input  logic      i_clk,
    input  logic      i_rst,
    input  logic      i_start,
    input  node_req_t i_req,
    output logic      o_done,
    output node_rsp_t o_rsp
);

localparam int n_nodes = `GOMOKU_MAX_DEPTH;

// element k links node k-1 to node k
logic      start_w [n_nodes+1];
node_req_t req_w   [n_nodes+1];
logic      done_w  [n_nodes+1];
node_rsp_t rsp_w   [n_nodes+1];

assign start_w[0]      = i_start;
assign req_w[0]        = i_req;
assign done_w[n_nodes] = 1'b0;  // nothing below the last node
assign rsp_w[n_nodes]  = '0;

for (genvar k = 0; k < n_nodes; k++) begin : g_node
    kill_node u_kill_node (
        .i_clk         (i_clk),
        .i_rst         (i_rst),
        .i_start       (start_w[k]),
        .i_req         (req_w[k]),
        .i_child_done  (done_w[k+1]),
        .i_child_rsp   (rsp_w[k+1]),
        .o_child_start (start_w[k+1]),
        .o_child_req   (req_w[k+1]),
        .o_done        (done_w[k]),
        .o_rsp         (rsp_w[k])
    );
end

assign o_done = done_w[0];
assign o_rsp  = rsp_w[0];

// the depth field never asks for more levels than the chain holds
a_chain_end: assert property (@(posedge i_clk) disable iff (i_rst)
    !start_w[n_nodes]);

endmodule

// File: tb/tb_kill_search.sv
// Forced win search testbench
`include "gomoku_defines.svh"

module tb_kill_search import board_pkg::*, search_pkg::*; ();

timeunit 1ns;
timeprecision 100ps;

logic      clk;
logic      rst;
logic      start;
node_req_t req;
logic      done;
node_rsp_t rsp;

node_req_t case_req [$];  // one request per trace case
node_rsp_t case_exp [$];  // expected answer of the same case
int        n_open;        // requests started but not yet answered
int        budget;        // watchdog length in cycles
bit        trace_read;

kill_search u_kill_search (
    .i_clk   (clk),
    .i_rst   (rst),
    .i_start (start),
    .i_req   (req),
    .o_done  (done),
    .o_rsp   (rsp)
);

initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
end

task automatic stop_run();
    $display("FAIL: see errors above");
    $fatal(1, "simulation stopped");
endtask

task automatic check_found(input logic got, input logic exp);
    if (got !== exp) begin
        $display("error: o_rsp.found is %h, expected %h", got, exp);
        stop_run();
    end
endtask

task automatic check_pos(input pos_t got, input pos_t exp);
    if (got !== exp) begin
        $display("error: o_rsp.pos is x=%h y=%h, expected x=%h y=%h",
                 got.x, got.y, exp.x, exp.y);
        stop_run();
    end
endtask

// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// done pulse monitor and watchdog
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
always @(posedge clk) begin
    if (!rst && done) begin
        if (n_open == 0) begin  // a repeated or stray done has nothing left to answer
            $display("o_done pulsed while no request was waiting for an answer");
            stop_run();
        end
        n_open--;
    end
    if (!rst && start) begin
        n_open++;
    end
end

initial begin
    wait (trace_read);
    repeat (budget) @(posedge clk);
    $display("timeout: the search gave no answer within %0d cycles", budget);
    stop_run();
end

// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// trace cases
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
initial begin
    int        fd;
    int        depth;
    int        found;
    int        ex;
    int        ey;
    int        count;
    int        sx;
    int        sy;
    int        colour;
    node_req_t r;
    node_rsp_t e;
    rst   = 1'b1;
    start = 1'b0;
    req   = '0;
    fd = $fopen("tb/kill_trace.txt", "r");
    if (fd == 0) begin
        $display("cannot open the trace file tb/kill_trace.txt");
        stop_run();
    end
    while ($fscanf(fd, "%d %d %d %d %d", depth, found, ex, ey, count) == 5) begin
        r       = '0;
        r.depth = 2'(depth);
        for (int k = 0; k < count; k++) begin
            void'($fscanf(fd, "%d %d %d", sx, sy, colour));
            r.board[sy * `GOMOKU_BOARD_N + sx] = cell_e'(colour);
        end
        e.found = 1'(found);
        e.pos.x = 4'(ex);
        e.pos.y = 4'(ey);
        case_req.push_back(r);
        case_exp.push_back(e);
        budget += 450 ** depth + 10;  // two board scans nested in each level
    end
    $fclose(fd);
    trace_read = 1'b1;
    repeat (2) @(negedge clk);
    rst = 1'b0;
    foreach (case_req[i]) begin
        @(negedge clk);
        req   = case_req[i];
        start = 1'b1;
        @(negedge clk);
        start = 1'b0;
        while (!done) @(negedge clk);
        check_found(rsp.found, case_exp[i].found);
        check_pos(rsp.pos, case_exp[i].pos);  // 0,0 is expected when nothing is found
    end
    repeat (4) @(negedge clk);  // leaves room for a stray done after the last case
    $display("PASS: all tests");
    $finish;
end

endmodule

// File: tb/kill_trace.txt
1 1 4 2 4
0 2 1
1 2 1
2 2 1
3 2 1
1 0 0 0 5
10 5 2
11 5 1
12 5 1
13 5 1
14 5 1
0 0 0 0 0
1 0 0 0 3
5 7 1
6 7 1
8 7 1
2 1 7 7 3
5 7 1
6 7 1
8 7 1
2 1 3 3 6
0 0 1
1 1 1
2 2 1
6 0 1
5 1 1
4 2 1

// File: src.f
+incdir+rtl
rtl/board_pkg.sv
rtl/search_pkg.sv
rtl/orth_runs.sv
rtl/diag_runs.sv
rtl/five_judge.sv
rtl/kill_node.sv
rtl/kill_search.sv
tb/tb_kill_search.sv

// File: Makefile
TOOL  := verilator
TOP   := tb_kill_search
FLIST := src.f
FLAGS := --timing --assert --top-module $(TOP)
LOG   := sim.log

.PHONY: lint sim clean

lint:
	$(TOOL) --lint-only $(FLAGS) -f $(FLIST)

sim:
	$(TOOL) --binary $(FLAGS) -f $(FLIST)
	./obj_dir/V$(TOP) | tee $(LOG)
	grep -q "PASS: all tests" $(LOG)

clean:
	rm -rf obj_dir $(LOG)
